// ==== src/core_decode_pkg.sv ====
// --------------------
// Shared widths, opcodes and reset address for the decode stage
// Instruction kind and immediate format enums
// Packed control structs and the decoded stage 2 bundle
// --------------------

package core_decode_pkg;

    // --------------------
    // Widths and addresses

    localparam int XLEN          = 32;                // Data and PC width
    localparam int REG_ADDR_W    = 5;                 // Register address width
    localparam int INSTR_W       = 32;                // Base instruction width
    localparam int OPC_W         = 7;                 // Major opcode width
    localparam logic [XLEN-1:0] PC_RESET_ADDR = 32'h1000_0000;
    localparam logic [XLEN-1:0] INSTR_BYTES   = 32'd4; // PC step per eat

    // --------------------
    // Major opcodes

    localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;
    localparam logic [OPC_W-1:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;
    localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPC_W-1:0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPC_W-1:0] OPC_STORE  = 7'b0100011;
    localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;

    localparam logic [6:0] F7_BASE = 7'b0000000;      // Normal funct7
    localparam logic [6:0] F7_ALT  = 7'b0100000;      // SUB and SRA/SRAI

    // --------------------
    // Decode enums

    typedef enum logic [3:0] {
        KIND_LUI,
        KIND_AUIPC,
        KIND_JAL,
        KIND_JALR,
        KIND_BRANCH,
        KIND_LOAD,
        KIND_STORE,
        KIND_OP_IMM,
        KIND_OP,
        KIND_INVALID
    } instr_kind_t;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_SHAMT,                                    // Zero-extended shift amount
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_t;

    // --------------------
    // Unit controls

    typedef struct packed {
        logic add;
        logic sub;
        logic and_op;
        logic or_op;
        logic xor_op;
        logic sll;
        logic srl;
        logic sra;
        logic slt;
        logic sltu;
    } alu_ctrl_t;

    typedef struct packed {
        logic beq;
        logic bne;
        logic blt;
        logic bge;
        logic bltu;
        logic bgeu;
        logic jal;
        logic jalr;
    } cfu_ctrl_t;

    typedef struct packed {
        logic load;
        logic store;
        logic byte_acc;
        logic half;
        logic word;
        logic sext;                                   // Sign extend loaded value
    } lsu_ctrl_t;

    typedef struct packed {
        logic alu;
        logic lsu;
        logic npc;                                    // Link address
    } wb_ctrl_t;

    typedef struct packed {
        alu_ctrl_t alu;
        cfu_ctrl_t cfu;
        lsu_ctrl_t lsu;
        wb_ctrl_t  wb;
    } uop_t;

    // Everything execute needs for one instruction
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1_addr;
        logic [REG_ADDR_W-1:0] rs2_addr;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       npc;
        logic [XLEN-1:0]       alu_lhs;
        logic [XLEN-1:0]       alu_rhs;
        logic [INSTR_W-1:0]    instr;
        logic                  trap;
        uop_t                  uop;
    } s2_decoded_t;

endpackage

// ==== src/core_instr_match.sv ====
// --------------------
// Instruction classifier for the 32-bit base integer set
// Legal encoding check, immediate format select, register fields
// --------------------

`timescale 1ns/1ps

module core_instr_match import core_decode_pkg::*; (
    input  logic [INSTR_W-1:0]    instr_i,            // Instruction word
    output instr_kind_t           kind_o,             // Instruction class
    output imm_fmt_t              imm_fmt_o,          // Immediate layout
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic                  trap_o              // Unrecognised word
);

    logic [OPC_W-1:0] opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             shift_op;
    logic             op_imm_ok;
    logic             op_ok;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // --------------------
    // Function field legality

    assign shift_op  = (funct3[1:0] == 2'b01);        // SLLI, SRLI, SRAI

    assign op_imm_ok = !shift_op                                             ||
                       (funct7 == F7_BASE)                                   ||
                       (funct7 == F7_ALT && funct3 == 3'b101);

    assign op_ok     = (funct7 == F7_BASE)                                   ||
                       (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101));

    // --------------------
    // Kind and immediate format

    always_comb begin
        kind_o    = KIND_INVALID;
        imm_fmt_o = IMM_NONE;
        case (opcode)
            OPC_LUI: begin
                kind_o    = KIND_LUI;
                imm_fmt_o = IMM_U;
            end
            OPC_AUIPC: begin
                kind_o    = KIND_AUIPC;
                imm_fmt_o = IMM_U;
            end
            OPC_JAL: begin
                kind_o    = KIND_JAL;
                imm_fmt_o = IMM_J;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    kind_o    = KIND_JALR;
                    imm_fmt_o = IMM_I;
                end
            end
            OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01) begin       // 010 and 011 unused
                    kind_o    = KIND_BRANCH;
                    imm_fmt_o = IMM_B;
                end
            end
            OPC_LOAD: begin
                if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
                    kind_o    = KIND_LOAD;
                    imm_fmt_o = IMM_I;
                end
            end
            OPC_STORE: begin
                if (funct3 < 3'b011) begin            // SB, SH, SW
                    kind_o    = KIND_STORE;
                    imm_fmt_o = IMM_S;
                end
            end
            OPC_OP_IMM: begin
                if (op_imm_ok) begin
                    kind_o    = KIND_OP_IMM;
                    imm_fmt_o = shift_op ? IMM_SHAMT : IMM_I;
                end
            end
            OPC_OP: begin
                if (op_ok) begin
                    kind_o = KIND_OP;
                end
            end
            default: begin
                kind_o = KIND_INVALID;                // System, fence, unknown
            end
        endcase
    end

    // --------------------
    // Register fields

    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    // No writeback for stores, branches or bad words
    assign rd_o = (kind_o == KIND_STORE || kind_o == KIND_BRANCH ||
                   kind_o == KIND_INVALID) ? '0 : instr_i[11:7];

    assign trap_o = (kind_o == KIND_INVALID);

endmodule

// ==== src/core_imm_gen.sv ====
// --------------------
// Immediate generator for I, shift, S, B, U and J layouts
// --------------------

`timescale 1ns/1ps

module core_imm_gen import core_decode_pkg::*; (
    input  logic [INSTR_W-1:0] instr_i,               // Instruction word
    input  imm_fmt_t           fmt_i,                 // Selected layout
    output logic [XLEN-1:0]    imm_o                  // Extended immediate
);

    logic sign;

    assign sign = instr_i[31];                        // Sign bit of every layout

    always_comb begin
        case (fmt_i)
            IMM_I: begin
                imm_o = {{(XLEN-12){sign}}, instr_i[31:20]};
            end
            IMM_SHAMT: begin
                imm_o = {{(XLEN-5){1'b0}}, instr_i[24:20]};
            end
            IMM_S: begin
                imm_o = {{(XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            end
            IMM_B: begin
                // Branch offset, bit 0 always zero
                imm_o = {{(XLEN-13){sign}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            end
            IMM_U: begin
                imm_o = {instr_i[31:12], 12'b0};      // Upper 20 bits
            end
            IMM_J: begin
                imm_o = {{(XLEN-21){sign}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;                           // IMM_NONE
            end
        endcase
    end

endmodule

// ==== src/core_uop_decode.sv ====
// --------------------
// Micro-op decoder
// ALU, control flow, load/store and writeback controls from kind and funct
// --------------------

`timescale 1ns/1ps

module core_uop_decode import core_decode_pkg::*; (
    input  logic [INSTR_W-1:0] instr_i,               // Instruction word
    input  instr_kind_t        kind_i,                // Class from the matcher
    output uop_t               uop_o                  // One-hot unit controls
);

    logic [2:0] funct3;
    logic       alt;                                  // funct7 bit 5

    assign funct3 = instr_i[14:12];
    assign alt    = instr_i[30];

    always_comb begin
        uop_o = '0;
        case (kind_i)
            KIND_LUI: begin
                uop_o.alu.or_op = 1'b1;               // Zero OR immediate
                uop_o.wb.alu    = 1'b1;
            end
            KIND_AUIPC: begin
                uop_o.alu.add = 1'b1;                 // PC plus immediate
                uop_o.wb.alu  = 1'b1;
            end
            KIND_JAL: begin
                uop_o.cfu.jal = 1'b1;
                uop_o.wb.npc  = 1'b1;
            end
            KIND_JALR: begin
                uop_o.cfu.jalr = 1'b1;
                uop_o.wb.npc   = 1'b1;
            end
            KIND_BRANCH: begin
                uop_o.alu.sub = 1'b1;                 // Compare by subtract
                case (funct3)
                    3'b000:  uop_o.cfu.beq  = 1'b1;
                    3'b001:  uop_o.cfu.bne  = 1'b1;
                    3'b100:  uop_o.cfu.blt  = 1'b1;
                    3'b101:  uop_o.cfu.bge  = 1'b1;
                    3'b110:  uop_o.cfu.bltu = 1'b1;
                    default: uop_o.cfu.bgeu = 1'b1;
                endcase
            end
            KIND_LOAD, KIND_STORE: begin
                uop_o.lsu.load     = (kind_i == KIND_LOAD);
                uop_o.lsu.store    = (kind_i == KIND_STORE);
                uop_o.lsu.byte_acc = (funct3[1:0] == 2'b00);
                uop_o.lsu.half     = (funct3[1:0] == 2'b01);
                uop_o.lsu.word     = (funct3[1:0] == 2'b10);
                // LB, LH, LW sign extend; LBU, LHU do not
                uop_o.lsu.sext     = (kind_i == KIND_LOAD) && !funct3[2];
                uop_o.wb.lsu       = (kind_i == KIND_LOAD);
            end
            KIND_OP_IMM, KIND_OP: begin
                uop_o.wb.alu = 1'b1;
                case (funct3)
                    3'b000: begin
                        // SUB exists only in the register form
                        if (kind_i == KIND_OP && alt) begin
                            uop_o.alu.sub = 1'b1;
                        end else begin
                            uop_o.alu.add = 1'b1;
                        end
                    end
                    3'b001:  uop_o.alu.sll    = 1'b1;
                    3'b010:  uop_o.alu.slt    = 1'b1;
                    3'b011:  uop_o.alu.sltu   = 1'b1;
                    3'b100:  uop_o.alu.xor_op = 1'b1;
                    3'b101: begin
                        uop_o.alu.sra = alt;          // Arithmetic shift
                        uop_o.alu.srl = !alt;
                    end
                    3'b110:  uop_o.alu.or_op  = 1'b1;
                    default: uop_o.alu.and_op = 1'b1;
                endcase
            end
            default: begin
                uop_o = '0;                           // Invalid, no unit acts
            end
        endcase
    end

endmodule

// ==== src/core_pc_track.sv ====
// --------------------
// Program counter register
// Redirect over eat priority, next PC adder
// --------------------

`timescale 1ns/1ps

module core_pc_track import core_decode_pkg::*; (
    input  logic            g_clk,
    input  logic            g_resetn,
    input  logic            eat_i,                    // Instruction consumed
    input  logic            cf_valid_i,               // Redirect requested
    input  logic            cf_ack_i,                 // Redirect accepted
    input  logic [XLEN-1:0] cf_target_i,              // Redirect destination
    output logic [XLEN-1:0] pc_o,
    output logic [XLEN-1:0] npc_o
);

    logic [XLEN-1:0] pc_q;
    logic            cf_change;

    assign cf_change = cf_valid_i && cf_ack_i;
    assign npc_o     = pc_q + INSTR_BYTES;
    assign pc_o      = pc_q;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= PC_RESET_ADDR;
        end else if (cf_change) begin
            pc_q <= cf_target_i;                      // Redirect wins
        end else if (eat_i) begin
            pc_q <= npc_o;
        end
    end

endmodule

// ==== src/core_pipe_decode.sv ====
// --------------------
// Decode and operand gather stage, top level
// Stage handshake, ALU operand select, stage 2 bundle assembly
// --------------------

`timescale 1ns/1ps

module core_pipe_decode import core_decode_pkg::*; (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  s1_valid_i,         // Fetch has a word
    input  logic [INSTR_W-1:0]    s1_instr_i,
    output logic                  s1_eat_o,           // Word consumed
    input  logic                  cf_valid_i,
    input  logic                  cf_ack_i,
    input  logic [XLEN-1:0]       cf_target_i,
    output logic [REG_ADDR_W-1:0] s1_rs1_addr_o,      // Register file reads
    input  logic [XLEN-1:0]       s1_rs1_data_i,
    output logic [REG_ADDR_W-1:0] s1_rs2_addr_o,
    input  logic [XLEN-1:0]       s1_rs2_data_i,
    input  logic                  s2_ready_i,         // Execute can accept
    output logic                  s2_valid_o,
    output s2_decoded_t           s2_o
);

    instr_kind_t           kind;
    imm_fmt_t              imm_fmt;
    logic [REG_ADDR_W-1:0] rd;
    logic                  trap;
    logic [XLEN-1:0]       imm;
    uop_t                  uop;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       npc;
    logic [XLEN-1:0]       alu_lhs;
    logic [XLEN-1:0]       alu_rhs;
    logic                  rhs_imm;

    // --------------------
    // Stage progression

    assign s1_eat_o   = s1_valid_i && s2_ready_i;
    assign s2_valid_o = s1_valid_i;

    // --------------------
    // Decode units

    core_instr_match u_match (
        .instr_i    (s1_instr_i),
        .kind_o     (kind),
        .imm_fmt_o  (imm_fmt),
        .rs1_addr_o (s1_rs1_addr_o),
        .rs2_addr_o (s1_rs2_addr_o),
        .rd_o       (rd),
        .trap_o     (trap)
    );

    core_imm_gen u_imm (
        .instr_i (s1_instr_i),
        .fmt_i   (imm_fmt),
        .imm_o   (imm)
    );

    core_uop_decode u_uop (
        .instr_i (s1_instr_i),
        .kind_i  (kind),
        .uop_o   (uop)
    );

    core_pc_track u_pc (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .eat_i       (s1_eat_o),
        .cf_valid_i  (cf_valid_i),
        .cf_ack_i    (cf_ack_i),
        .cf_target_i (cf_target_i),
        .pc_o        (pc),
        .npc_o       (npc)
    );

    // --------------------
    // Operand select

    assign rhs_imm = (kind == KIND_OP_IMM) || (kind == KIND_LOAD)  ||
                     (kind == KIND_STORE)  || (kind == KIND_LUI)   ||
                     (kind == KIND_AUIPC);

    assign alu_lhs = (kind == KIND_AUIPC) ? pc           :
                     (kind == KIND_LUI)   ? {XLEN{1'b0}} :
                                            s1_rs1_data_i;

    assign alu_rhs = rhs_imm ? imm : s1_rs2_data_i;

    always_comb begin
        s2_o          = '0;
        s2_o.rs1_addr = s1_rs1_addr_o;
        s2_o.rs2_addr = s1_rs2_addr_o;
        s2_o.rd       = rd;
        s2_o.rs1_data = s1_rs1_data_i;
        s2_o.rs2_data = s1_rs2_data_i;
        s2_o.imm      = imm;
        s2_o.pc       = pc;
        s2_o.npc      = npc;
        s2_o.alu_lhs  = alu_lhs;
        s2_o.alu_rhs  = alu_rhs;
        s2_o.instr    = s1_instr_i;
        s2_o.trap     = trap;
        s2_o.uop      = uop;
    end

endmodule

// ==== tests/tb_decode_table.svh ====
// --------------------
// Decode table of instruction words with expected fields
// Entry type, storage and fill task
// --------------------

`ifndef TB_DECODE_TABLE_SVH
`define TB_DECODE_TABLE_SVH

typedef struct packed {
    logic [INSTR_W-1:0]    instr;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;
    logic [9:0]            alu;                       // add sub and or xor sll srl sra slt sltu
    logic [7:0]            cfu;                       // beq bne blt bge bltu bgeu jal jalr
    logic [5:0]            lsu;                       // load store byte half word sext
    logic [2:0]            wb;                        // alu lsu npc
    logic                  trap;
} decode_entry_t;

localparam int MAX_ENTRIES = 32;

decode_entry_t decode_table [MAX_ENTRIES];
int            entry_count;

task automatic add_entry(input logic [INSTR_W-1:0] instr, input int rd, input int rs1,
                         input int rs2, input logic [XLEN-1:0] imm, input int alu,
                         input int cfu, input int lsu, input int wb, input int trap);
    decode_table[entry_count] = '{instr, rd[4:0], rs1[4:0], rs2[4:0], imm, alu[9:0],
                                  cfu[7:0], lsu[5:0], wb[2:0], trap[0]};
    entry_count++;
endtask

task automatic load_decode_table();
    entry_count = 0;
    // Columns: instr, rd, rs1, rs2, imm, alu, cfu, lsu, wb, trap
    add_entry(32'h00510093, 1, 2, 5, 32'h00000005, 'h200, 'h00, 'h00, 'h4, 0);   // addi
    add_entry(32'hFFF20193, 3, 4, 31, 32'hFFFFFFFF, 'h200, 'h00, 'h00, 'h4, 0);  // addi -1
    add_entry(32'h00731293, 5, 6, 7, 32'h00000007, 'h010, 'h00, 'h00, 'h4, 0);   // slli
    add_entry(32'h41F45393, 7, 8, 31, 32'h0000001F, 'h004, 'h00, 'h00, 'h4, 0);  // srai
    add_entry(32'h00B504B3, 9, 10, 11, 32'h00000000, 'h200, 'h00, 'h00, 'h4, 0); // add
    add_entry(32'h40E68633, 12, 13, 14, 32'h00000000, 'h100, 'h00, 'h00, 'h4, 0);
    add_entry(32'h011837B3, 15, 16, 17, 32'h00000000, 'h001, 'h00, 'h00, 'h4, 0);
    add_entry(32'hFF89A903, 18, 19, 24, 32'hFFFFFFF8, 'h000, 'h00, 'h23, 'h2, 0); // lw
    add_entry(32'h003ACA03, 20, 21, 3, 32'h00000003, 'h000, 'h00, 'h28, 'h2, 0);  // lbu
    add_entry(32'hFF6B9E23, 0, 23, 22, 32'hFFFFFFFC, 'h000, 'h00, 'h14, 'h0, 0);  // sh
    add_entry(32'h018CAA23, 0, 25, 24, 32'h00000014, 'h000, 'h00, 'h12, 'h0, 0);  // sw
    add_entry(32'hFE2088E3, 0, 1, 2, 32'hFFFFFFF0, 'h100, 'h80, 'h00, 'h0, 0);    // beq
    add_entry(32'h0041F0E3, 0, 3, 4, 32'h00000800, 'h100, 'h04, 'h00, 'h0, 0);    // bgeu
    add_entry(32'hABCDED37, 26, 27, 28, 32'hABCDE000, 'h040, 'h00, 'h00, 'h4, 0); // lui
    add_entry(32'hFFFFFD97, 27, 31, 31, 32'hFFFFF000, 'h200, 'h00, 'h00, 'h4, 0); // auipc
    add_entry(32'h801FF0EF, 1, 31, 1, 32'hFFFFF800, 'h000, 'h02, 'h00, 'h1, 0);   // jal
    add_entry(32'h00C302E7, 5, 6, 12, 32'h0000000C, 'h000, 'h01, 'h00, 'h1, 0);   // jalr
    // Illegal words
    add_entry(32'h00000073, 0, 0, 0, 32'h00000000, 'h000, 'h00, 'h00, 'h0, 1);   // ecall
    add_entry(32'h300110F3, 0, 2, 0, 32'h00000000, 'h000, 'h00, 'h00, 'h0, 1);   // csrrw
    add_entry(32'h023100B3, 0, 2, 3, 32'h00000000, 'h000, 'h00, 'h00, 'h0, 1);   // mul
    add_entry(32'hFFFFFFFF, 0, 31, 31, 32'h00000000, 'h000, 'h00, 'h00, 'h0, 1);
endtask

`endif

// ==== tests/tb_core_pipe_decode.sv ====
// --------------------
// Testbench for the decode and operand gather stage
// Table driven decode checks, PC tracking, back-pressure and redirects
// --------------------

`timescale 1ns/1ps

module tb_core_pipe_decode import core_decode_pkg::*; ();

    localparam int          CLK_PERIOD   = 20;
    localparam int          SAMPLE_DELAY = CLK_PERIOD / 2 - 1;   // Just before rising edge
    localparam int          RESET_CYCLES = 3;
    localparam int          MAX_STALLS   = 3;                    // Then ready is forced high
    localparam int          EAT_TIMEOUT  = 8;
    localparam logic [31:0] LCG_SEED     = 32'd70;

    logic                  g_clk;
    logic                  g_resetn;
    logic                  s1_valid;
    logic [INSTR_W-1:0]    s1_instr;
    logic                  s1_eat;
    logic                  cf_valid;
    logic                  cf_ack;
    logic [XLEN-1:0]       cf_target;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  s2_ready;
    logic                  s2_valid;
    s2_decoded_t           s2;

    logic [31:0]     lcg_state;
    logic [XLEN-1:0] exp_pc;                          // Reference PC
    int              err_count;
    int              check_count;
    bit              run_ok;

    `include "tb_decode_table.svh"

    core_pipe_decode uut (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .s1_valid_i    (s1_valid),
        .s1_instr_i    (s1_instr),
        .s1_eat_o      (s1_eat),
        .cf_valid_i    (cf_valid),
        .cf_ack_i      (cf_ack),
        .cf_target_i   (cf_target),
        .s1_rs1_addr_o (rs1_addr),
        .s1_rs1_data_i (rs1_data),
        .s1_rs2_addr_o (rs2_addr),
        .s1_rs2_data_i (rs2_data),
        .s2_ready_i    (s2_ready),
        .s2_valid_o    (s2_valid),
        .s2_o          (s2)
    );

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    // --------------------
    // Helpers

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [XLEN-1:0] expected_lhs(input decode_entry_t e);
        if (e.trap) return rs1_data;
        if (e.instr[6:0] == OPC_AUIPC) return exp_pc;
        if (e.instr[6:0] == OPC_LUI) return '0;
        return rs1_data;
    endfunction

    function automatic logic [XLEN-1:0] expected_rhs(input decode_entry_t e);
        logic [OPC_W-1:0] opc;
        opc = e.instr[6:0];
        if (!e.trap && (opc == OPC_OP_IMM || opc == OPC_LOAD || opc == OPC_STORE ||
                        opc == OPC_LUI || opc == OPC_AUIPC)) begin
            return e.imm;
        end
        return rs2_data;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        assert (act === exp) else begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_handshake();
        check_value("s1_eat_o", 32'(s1_valid && s2_ready), 32'(s1_eat));
        check_value("s2_valid_o", 32'(s1_valid), 32'(s2_valid));
        check_value("s2_o.pc", exp_pc, s2.pc);
        check_value("s2_o.npc", exp_pc + INSTR_BYTES, s2.npc);
    endtask

    task automatic check_decode(input decode_entry_t e);
        check_value("s1_rs1_addr_o", 32'(e.rs1), 32'(rs1_addr));
        check_value("s1_rs2_addr_o", 32'(e.rs2), 32'(rs2_addr));
        check_value("s2_o.rs1_addr", 32'(e.rs1), 32'(s2.rs1_addr));
        check_value("s2_o.rs2_addr", 32'(e.rs2), 32'(s2.rs2_addr));
        check_value("s2_o.rs1_data", rs1_data, s2.rs1_data);
        check_value("s2_o.rs2_data", rs2_data, s2.rs2_data);
        check_value("s2_o.rd", 32'(e.rd), 32'(s2.rd));
        check_value("s2_o.imm", e.imm, s2.imm);
        check_value("s2_o.uop.alu", 32'(e.alu), 32'(s2.uop.alu));
        check_value("s2_o.uop.cfu", 32'(e.cfu), 32'(s2.uop.cfu));
        check_value("s2_o.uop.lsu", 32'(e.lsu), 32'(s2.uop.lsu));
        check_value("s2_o.uop.wb", 32'(e.wb), 32'(s2.uop.wb));
        check_value("s2_o.trap", 32'(e.trap), 32'(s2.trap));
        check_value("s2_o.alu_lhs", expected_lhs(e), s2.alu_lhs);
        check_value("s2_o.alu_rhs", expected_rhs(e), s2.alu_rhs);
        check_value("s2_o.instr", e.instr, s2.instr);
    endtask

    // Update the reference PC from the driven inputs, then move to the next falling edge
    task automatic advance_cycle();
        if (cf_valid && cf_ack) begin
            exp_pc = cf_target;                       // Redirect first
        end else if (s1_valid && s2_ready) begin
            exp_pc = exp_pc + INSTR_BYTES;
        end
        @(negedge g_clk);
    endtask

    // --------------------
    // Stimulus sequences

    task automatic apply_entry(input int idx, output bit ok);
        decode_entry_t e;
        int            stalls;
        bit            eaten;
        e      = decode_table[idx];
        stalls = 0;
        eaten  = 1'b0;
        ok     = 1'b1;
        s1_valid  = 1'b1;
        s1_instr  = e.instr;
        lcg_state = lcg_step(lcg_state);
        rs1_data  = lcg_state;
        lcg_state = lcg_step(lcg_state);
        rs2_data  = lcg_state;
        while (!eaten && ok) begin
            lcg_state = lcg_step(lcg_state);
            s2_ready  = (stalls >= MAX_STALLS) || lcg_state[16];
            #(SAMPLE_DELAY);
            check_handshake();
            check_decode(e);
            eaten = s1_eat;
            advance_cycle();
            stalls++;
            if (!eaten && stalls > EAT_TIMEOUT) begin
                $display("Timeout: entry %0d was never consumed by the decoder", idx);
                err_count++;
                ok = 1'b0;
            end
        end
    endtask

    task automatic check_reset_state();
        s1_valid = 1'b0;
        s2_ready = 1'b1;
        #(SAMPLE_DELAY);
        check_value("s2_o.pc after reset", PC_RESET_ADDR, s2.pc);
        check_handshake();
        advance_cycle();
    endtask

    task automatic check_redirects();
        // Redirect in the same cycle as an eat
        s1_valid  = 1'b1;
        s1_instr  = decode_table[0].instr;
        s2_ready  = 1'b1;
        cf_valid  = 1'b1;
        cf_ack    = 1'b1;
        cf_target = 32'h2000_0040;
        #(SAMPLE_DELAY);
        check_handshake();
        advance_cycle();
        // Request without acknowledge and no word from fetch
        s1_valid  = 1'b0;
        cf_ack    = 1'b0;
        cf_target = 32'h3000_0000;
        #(SAMPLE_DELAY);
        check_value("s2_o.pc after redirect", 32'h2000_0040, s2.pc);
        check_handshake();
        advance_cycle();
        // Redirect alone
        cf_ack    = 1'b1;
        cf_target = 32'h3000_0100;
        #(SAMPLE_DELAY);
        check_value("s2_o.pc without ack", 32'h2000_0040, s2.pc);
        check_handshake();
        advance_cycle();
        cf_valid = 1'b0;
        cf_ack   = 1'b0;
        #(SAMPLE_DELAY);
        check_value("s2_o.pc after lone redirect", 32'h3000_0100, s2.pc);
        check_handshake();
        advance_cycle();
    endtask

    // --------------------
    // Main sequence

    initial begin
        g_resetn    = 1'b0;
        s1_valid    = 1'b0;
        s1_instr    = '0;
        s2_ready    = 1'b0;
        cf_valid    = 1'b0;
        cf_ack      = 1'b0;
        cf_target   = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        lcg_state   = LCG_SEED;
        exp_pc      = PC_RESET_ADDR;
        err_count   = 0;
        check_count = 0;
        run_ok      = 1'b1;
        load_decode_table();
        repeat (RESET_CYCLES) @(negedge g_clk);
        g_resetn = 1'b1;
        check_reset_state();
        for (int i = 0; i < entry_count && run_ok; i++) begin
            apply_entry(i, run_ok);
        end
        if (run_ok) begin
            check_redirects();
        end
        $display("Checks run: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== core_pipe_decode.f ====
+incdir+tests
src/core_decode_pkg.sv
src/core_instr_match.sv
src/core_imm_gen.sv
src/core_uop_decode.sv
src/core_pc_track.sv
src/core_pipe_decode.sv
tests/tb_core_pipe_decode.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f core_pipe_decode.f \
    --top-module tb_core_pipe_decode -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
